// File: design/rob_pkg.sv
// reorder buffer shared types
package rob_pkg;

  // ============================
  // widths
  // ============================
  // lane counts are fixed, the commit masks are written for two lanes
  localparam int DISPATCH_WIDTH = 2;
  localparam int COMMIT_WIDTH   = 2;
  localparam int NUM_ALU_WB     = 2;

  localparam int ADDR_W         = 32;
  localparam int ARCH_REG_W     = 5;
  localparam int PHY_REG_W      = 6;
  localparam int EXCP_CODE_W    = 6;
  // index field in transport structs, wide enough for 64 entries
  localparam int ROB_MAX_IDX_W  = 6;

  // ============================
  // encodings
  // ============================
  typedef enum logic [1:0] {
    kind_alu    = 2'd0,
    kind_branch = 2'd1,
    kind_mem    = 2'd2,
    kind_other  = 2'd3
  } instr_kind_t;

  typedef enum logic [1:0] {
    mem_load   = 2'd0,
    mem_store  = 2'd1,
    mem_atomic = 2'd2
  } mem_op_t;

  // info word, meaning depends on what completed the entry
  typedef union packed {
    logic [ADDR_W-1:0] br_target;
    logic [ADDR_W-1:0] fault_vaddr;
  } rob_info_u;

  // ============================
  // entry and transport structs
  // ============================
  typedef struct packed {
    logic                   complete;
    logic [ADDR_W-1:0]      pc;
    instr_kind_t            kind;
    logic [ARCH_REG_W-1:0]  arch_reg;
    logic [PHY_REG_W-1:0]   phy_reg;
    logic [PHY_REG_W-1:0]   old_phy_reg;
    logic                   excp_valid;
    logic [EXCP_CODE_W-1:0] excp_code;
    logic                   br_redirect;
    rob_info_u              info;
  } rob_entry_t;

  typedef struct packed {
    logic                   valid;
    logic [ADDR_W-1:0]      pc;
    instr_kind_t            kind;
    logic [ARCH_REG_W-1:0]  arch_reg;
    logic [PHY_REG_W-1:0]   phy_reg;
    logic [PHY_REG_W-1:0]   old_phy_reg;
    logic                   excp_valid;
    logic [EXCP_CODE_W-1:0] excp_code;
  } dispatch_t;

  typedef struct packed {
    logic                     valid;
    logic [ROB_MAX_IDX_W-1:0] idx;
    dispatch_t                disp;
  } alloc_lane_t;

  typedef struct packed {
    alloc_lane_t [DISPATCH_WIDTH-1:0] lane;
  } alloc_wr_t;

  typedef struct packed {
    logic                     valid;
    logic [ROB_MAX_IDX_W-1:0] rob_idx;
    logic                     br_redirect;
    logic [ADDR_W-1:0]        br_target;
  } alu_wb_t;

  typedef struct packed {
    logic                     valid;
    logic [ROB_MAX_IDX_W-1:0] rob_idx;
    mem_op_t                  mem_op;
    logic                     excp_valid;
    logic [EXCP_CODE_W-1:0]   excp_code;
    logic [ADDR_W-1:0]        vaddr;
  } mem_wb_t;

  typedef struct packed {
    logic       [COMMIT_WIDTH-1:0] valid;
    rob_entry_t [COMMIT_WIDTH-1:0] entry;
  } commit_t;

endpackage

// File: design/rob_alloc.sv
// reorder buffer allocation stage
`timescale 1ns/10ps

module rob_alloc #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     flush,
  input  rob_pkg::dispatch_t [rob_pkg::DISPATCH_WIDTH-1:0]         dispatch,
  input  logic                                                     alloc_ready,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0][$clog2(ROB_DEPTH)-1:0] alloc_idx,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0]                       alloc_pos,
  output rob_pkg::alloc_wr_t                                       wr
);

  import rob_pkg::*;

  localparam int IDX_W = $clog2(ROB_DEPTH);

  // tail carries one extra wrap bit
  logic [IDX_W:0]                      tail;
  logic [DISPATCH_WIDTH-1:0][IDX_W:0]  lane_ptr;
  logic [DISPATCH_WIDTH-1:0]           lane_take;
  logic [1:0]                          alloc_cnt;

  logic [DISPATCH_WIDTH-1:0]            wr_valid_q;
  logic [DISPATCH_WIDTH-1:0][IDX_W-1:0] wr_idx_q;
  dispatch_t [DISPATCH_WIDTH-1:0]       wr_disp_q;

  // ============================
  // slot numbering
  // ============================
  always_comb begin
    // valid lanes get consecutive slots, an idle lane 0 leaves no hole
    lane_ptr[0] = tail;
    lane_ptr[1] = tail + (IDX_W+1)'(dispatch[0].valid);
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      alloc_idx[i] = lane_ptr[i][IDX_W-1:0];
      alloc_pos[i] = lane_ptr[i][IDX_W];
      lane_take[i] = alloc_ready & dispatch[i].valid;
    end
    alloc_cnt = {1'b0, lane_take[0]} + {1'b0, lane_take[1]};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail       <= '0;
      wr_valid_q <= '0;
    end else if (flush) begin
      tail       <= '0;
      wr_valid_q <= '0;
    end else begin
      tail       <= tail + (IDX_W+1)'(alloc_cnt);
      wr_valid_q <= lane_take;
    end
  end

  // payload follows the lanes, qualified by wr_valid_q
  always_ff @(posedge clk) begin
    wr_idx_q  <= alloc_idx;
    wr_disp_q <= dispatch;
  end

  // ============================
  // write request to the table
  // ============================
  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      wr.lane[i].valid = wr_valid_q[i];
      wr.lane[i].idx   = ROB_MAX_IDX_W'(wr_idx_q[i]);
      wr.lane[i].disp  = wr_disp_q[i];
    end
  end

endmodule

// File: design/rob_table.sv
// reorder buffer entry table
`timescale 1ns/10ps

module rob_table #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 flush,
  input  rob_pkg::alloc_wr_t                                   wr,
  input  rob_pkg::alu_wb_t [rob_pkg::NUM_ALU_WB-1:0]           alu_wb,
  input  rob_pkg::mem_wb_t                                     mem_wb,
  input  logic [1:0]                                           retire_cnt,
  output logic                                                 alloc_ready,
  output logic                                                 mem_wb_ready,
  output rob_pkg::rob_entry_t [rob_pkg::COMMIT_WIDTH-1:0]      head_entry,
  output logic [rob_pkg::COMMIT_WIDTH-1:0]                     head_live
);

  import rob_pkg::*;

  localparam int IDX_W = $clog2(ROB_DEPTH);
  localparam int CNT_W = IDX_W + 1;

  rob_entry_t       entries   [ROB_DEPTH];
  rob_entry_t       entries_n [ROB_DEPTH];
  rob_entry_t       new_entry;
  logic [IDX_W-1:0] head;
  logic [CNT_W-1:0] count;
  logic [1:0]       wr_cnt;
  logic [CNT_W:0]   occ;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] alu_idx;
  logic [IDX_W-1:0] mem_idx;

  // ============================
  // ready rules
  // ============================
  always_comb begin
    // lanes still in the alloc register are counted as occupied
    wr_cnt      = {1'b0, wr.lane[0].valid} + {1'b0, wr.lane[1].valid};
    occ         = {1'b0, count} + (CNT_W+1)'(wr_cnt);
    alloc_ready = occ <= (CNT_W+1)'(ROB_DEPTH - 2);

    // anything other than a plain load waits to be the oldest
    mem_idx      = mem_wb.rob_idx[IDX_W-1:0];
    mem_wb_ready = (mem_wb.mem_op == mem_load) || (mem_idx == head);
  end

  // head window for the commit stage
  always_comb begin
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      head_entry[i] = entries[head + IDX_W'(i)];
      head_live[i]  = count > CNT_W'(i);
    end
  end

  // ============================
  // entry updates
  // ============================
  always_comb begin
    entries_n = entries;
    new_entry = '0;
    wr_idx    = '0;
    alu_idx   = '0;

    // allocation first
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      if (wr.lane[i].valid) begin
        wr_idx                = wr.lane[i].idx[IDX_W-1:0];
        new_entry             = '0;
        // an exception at dispatch needs no execution
        new_entry.complete    = wr.lane[i].disp.excp_valid;
        new_entry.pc          = wr.lane[i].disp.pc;
        new_entry.kind        = wr.lane[i].disp.kind;
        new_entry.arch_reg    = wr.lane[i].disp.arch_reg;
        new_entry.phy_reg     = wr.lane[i].disp.phy_reg;
        new_entry.old_phy_reg = wr.lane[i].disp.old_phy_reg;
        new_entry.excp_valid  = wr.lane[i].disp.excp_valid;
        new_entry.excp_code   = wr.lane[i].disp.excp_code;
        new_entry.info.fault_vaddr = wr.lane[i].disp.pc;
        entries_n[wr_idx]     = new_entry;
      end
    end

    // then the alu ports, always accepted
    for (int i = 0; i < NUM_ALU_WB; i++) begin
      if (alu_wb[i].valid) begin
        alu_idx                       = alu_wb[i].rob_idx[IDX_W-1:0];
        entries_n[alu_idx].complete    = 1'b1;
        entries_n[alu_idx].br_redirect = alu_wb[i].br_redirect;
        if (alu_wb[i].br_redirect) begin
          entries_n[alu_idx].info.br_target = alu_wb[i].br_target;
        end
      end
    end

    // memory port last
    if (mem_wb.valid && mem_wb_ready) begin
      entries_n[mem_idx].complete         = 1'b1;
      entries_n[mem_idx].br_redirect      = 1'b0;
      entries_n[mem_idx].excp_valid       = mem_wb.excp_valid;
      entries_n[mem_idx].excp_code        = mem_wb.excp_code;
      entries_n[mem_idx].info.fault_vaddr = mem_wb.vaddr;
    end
  end

  always_ff @(posedge clk) begin
    entries <= entries_n;
  end

  // ============================
  // head and occupancy
  // ============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= '0;
      count <= '0;
    end else begin
      head  <= head + IDX_W'(retire_cnt);
      count <= count + CNT_W'(wr_cnt) - CNT_W'(retire_cnt);
    end
  end

endmodule

// File: design/rob_commit.sv
// reorder buffer commit stage
`timescale 1ns/10ps

module rob_commit (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            flush,
  input  rob_pkg::rob_entry_t [rob_pkg::COMMIT_WIDTH-1:0] head_entry,
  input  logic [rob_pkg::COMMIT_WIDTH-1:0]                head_live,
  output logic [1:0]                                      retire_cnt,
  output rob_pkg::commit_t                                commit
);

  import rob_pkg::*;

  logic                     redirect_mask;
  logic                     excp_mask;
  logic                     br_mask;
  logic [COMMIT_WIDTH-1:0]  retire_vld;

  logic [COMMIT_WIDTH-1:0]  commit_vld_q;
  rob_entry_t [COMMIT_WIDTH-1:0] commit_entry_q;

  // ============================
  // retire selection
  // ============================
  always_comb begin
    // masks apply to lane 1 only, the oldest entry is never masked
    // redirect drains the pipe, so it retires without a partner
    redirect_mask = ~head_entry[0].br_redirect & ~head_entry[1].br_redirect;
    // same for exceptions
    excp_mask     = ~head_entry[0].excp_valid & ~head_entry[1].excp_valid;
    // one branch per cycle
    br_mask       = head_entry[0].kind != kind_branch;

    // in-order chain, lane 1 needs lane 0
    retire_vld[0] = head_live[0] & head_entry[0].complete;
    retire_vld[1] = retire_vld[0] & head_live[1] & head_entry[1].complete
                  & redirect_mask & excp_mask & br_mask;

    retire_cnt = {1'b0, retire_vld[0]} + {1'b0, retire_vld[1]};
  end

  // ============================
  // registered commit output
  // ============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_vld_q <= '0;
    end else if (flush) begin
      commit_vld_q <= '0;
    end else begin
      commit_vld_q <= retire_vld;
    end
  end

  always_ff @(posedge clk) begin
    commit_entry_q <= head_entry;
  end

  always_comb begin
    commit.valid = commit_vld_q;
    commit.entry = commit_entry_q;
  end

endmodule

// File: design/rob_top.sv
// reorder buffer top level
`timescale 1ns/10ps

module rob_top #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     flush,
  input  rob_pkg::dispatch_t [rob_pkg::DISPATCH_WIDTH-1:0]         dispatch,
  input  rob_pkg::alu_wb_t [rob_pkg::NUM_ALU_WB-1:0]               alu_wb,
  input  rob_pkg::mem_wb_t                                         mem_wb,
  output logic                                                     alloc_ready,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0][$clog2(ROB_DEPTH)-1:0] alloc_idx,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0]                       alloc_pos,
  output logic                                                     mem_wb_ready,
  output rob_pkg::commit_t                                         commit
);

  import rob_pkg::*;

  // stage to stage wires
  alloc_wr_t                     wr;
  rob_entry_t [COMMIT_WIDTH-1:0] head_entry;
  logic [COMMIT_WIDTH-1:0]       head_live;
  logic [1:0]                    retire_cnt;

  rob_alloc #(
    .ROB_DEPTH(ROB_DEPTH)
  ) u_alloc (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .dispatch   (dispatch),
    .alloc_ready(alloc_ready),
    .alloc_idx  (alloc_idx),
    .alloc_pos  (alloc_pos),
    .wr         (wr)
  );

  rob_table #(
    .ROB_DEPTH(ROB_DEPTH)
  ) u_table (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .wr          (wr),
    .alu_wb      (alu_wb),
    .mem_wb      (mem_wb),
    .retire_cnt  (retire_cnt),
    .alloc_ready (alloc_ready),
    .mem_wb_ready(mem_wb_ready),
    .head_entry  (head_entry),
    .head_live   (head_live)
  );

  rob_commit u_commit (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .head_entry(head_entry),
    .head_live (head_live),
    .retire_cnt(retire_cnt),
    .commit    (commit)
  );

endmodule

// File: tests/rob_properties.sv
// reorder buffer assertions
`timescale 1ns/10ps

module rob_properties #(
  parameter int ROB_DEPTH = 8
) (
  input logic                                     clk,
  input logic                                     rst_n,
  input logic [$clog2(ROB_DEPTH):0]               count,
  input logic [$clog2(ROB_DEPTH)-1:0]             head,
  input rob_pkg::commit_t                         commit,
  input rob_pkg::alu_wb_t [rob_pkg::NUM_ALU_WB-1:0] alu_wb,
  input rob_pkg::mem_wb_t                         mem_wb
);

  import rob_pkg::*;

  localparam int IDX_W = $clog2(ROB_DEPTH);

  // distance from the head must fall below the occupancy
  function automatic logic in_window(input logic [ROB_MAX_IDX_W-1:0] idx);
    logic [IDX_W-1:0] off;
    off = idx[IDX_W-1:0] - head;
    return {1'b0, off} < count;
  endfunction

  a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
    count <= ROB_DEPTH)
    else $error("occupancy above buffer depth");

  a_lane_order: assert property (@(posedge clk) disable iff (!rst_n)
    commit.valid[1] |-> commit.valid[0])
    else $error("second commit lane valid without the first");

  a_one_branch: assert property (@(posedge clk) disable iff (!rst_n)
    !(commit.valid == 2'b11 && commit.entry[0].kind == kind_branch &&
      commit.entry[1].kind == kind_branch))
    else $error("two branches retired together");

  a_alu0_window: assert property (@(posedge clk) disable iff (!rst_n)
    alu_wb[0].valid |-> in_window(alu_wb[0].rob_idx))
    else $error("alu port 0 writeback outside live window");

  a_alu1_window: assert property (@(posedge clk) disable iff (!rst_n)
    alu_wb[1].valid |-> in_window(alu_wb[1].rob_idx))
    else $error("alu port 1 writeback outside live window");

  a_mem_window: assert property (@(posedge clk) disable iff (!rst_n)
    mem_wb.valid |-> in_window(mem_wb.rob_idx))
    else $error("memory writeback outside live window");

endmodule

bind rob_top rob_properties #(
  .ROB_DEPTH(ROB_DEPTH)
) u_props (
  .clk   (clk),
  .rst_n (rst_n),
  .count (u_table.count),
  .head  (u_table.head),
  .commit(commit),
  .alu_wb(alu_wb),
  .mem_wb(mem_wb)
);

// File: tests/tb_rob.sv
// reorder buffer testbench
`timescale 1ns/10ps

module tb_rob;

  import rob_pkg::*;

  localparam int ROB_DEPTH = 8;
  localparam int IDX_W     = $clog2(ROB_DEPTH);
  localparam int TIMEOUT   = 200;

  typedef struct packed {
    instr_kind_t kind;
    logic        redirect;
    logic        dexc;
    mem_op_t     mem_op;
    logic        mexc;
    logic        last;
  } row_t;

  logic                            clk;
  logic                            rst_n;
  logic                            flush;
  dispatch_t [DISPATCH_WIDTH-1:0]  dispatch;
  alu_wb_t [NUM_ALU_WB-1:0]        alu_wb;
  mem_wb_t                         mem_wb;
  logic                            alloc_ready;
  logic [DISPATCH_WIDTH-1:0][IDX_W-1:0] alloc_idx;
  logic [DISPATCH_WIDTH-1:0]       alloc_pos;
  logic                            mem_wb_ready;
  commit_t                         commit;

  integer     seed;
  // allocation position over two passes, the upper half is the wrap bit
  int         tail_model;
  row_t       stim [$];
  rob_entry_t model_q [$];

  rob_top #(
    .ROB_DEPTH(ROB_DEPTH)
  ) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .dispatch    (dispatch),
    .alu_wb      (alu_wb),
    .mem_wb      (mem_wb),
    .alloc_ready (alloc_ready),
    .alloc_idx   (alloc_idx),
    .alloc_pos   (alloc_pos),
    .mem_wb_ready(mem_wb_ready),
    .commit      (commit)
  );

  always #2 clk = ~clk;

  // ==============================
  // checks
  // ==============================
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_entry(input string name, input rob_entry_t got, input rob_entry_t exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_commit_valid(input logic [COMMIT_WIDTH-1:0] got,
                                    input logic [COMMIT_WIDTH-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: commit.valid got %h expected %h", got, exp));
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_idx(input string name, input logic [IDX_W-1:0] got,
                           input logic [IDX_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_pos(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  // ==============================
  // reference model
  // ==============================
  // lane 1 joins only behind a plain, non-branch oldest entry
  function automatic logic [1:0] expected_group();
    logic [1:0] grp;
    grp = 2'b01;
    if (model_q.size() >= 2) begin
      if (!model_q[0].br_redirect && !model_q[0].excp_valid &&
          !model_q[1].br_redirect && !model_q[1].excp_valid &&
          model_q[0].kind != kind_branch) begin
        grp = 2'b11;
      end
    end
    return grp;
  endfunction

  function automatic dispatch_t to_dispatch(input rob_entry_t e, input logic dexc);
    dispatch_t d;
    d             = '0;
    d.valid       = 1'b1;
    d.pc          = e.pc;
    d.kind        = e.kind;
    d.arch_reg    = e.arch_reg;
    d.phy_reg     = e.phy_reg;
    d.old_phy_reg = e.old_phy_reg;
    d.excp_valid  = dexc;
    d.excp_code   = dexc ? e.excp_code : '0;
    return d;
  endfunction

  task automatic add_row(input instr_kind_t kind, input logic redirect, input logic dexc,
                         input mem_op_t op, input logic mexc, input logic last);
    row_t r;
    r.kind     = kind;
    r.redirect = redirect;
    r.dexc     = dexc;
    r.mem_op   = op;
    r.mexc     = mexc;
    r.last     = last;
    stim.push_back(r);
  endtask

  // ==============================
  // batch of rows
  // ==============================
  task automatic run_batch(input int first, input int num);
    rob_entry_t                     exp_e [$];
    int                             slot [$];
    int                             order [$];
    rob_entry_t                     e;
    row_t                           r;
    dispatch_t [DISPATCH_WIDTH-1:0] pair;
    int                             waited;
    int                             j;
    int                             tmp;
    int                             port;
    int                             k;
    logic [1:0]                     exp_vld;
    for (int n = 0; n < num; n++) begin
      r = stim[first+n];
      e = '0;
      e.complete    = 1'b1;
      e.pc          = 32'h0000_1000 + 32'((first + n) * 4);
      e.kind        = r.kind;
      e.arch_reg    = ARCH_REG_W'($random(seed));
      e.phy_reg     = PHY_REG_W'($random(seed));
      e.old_phy_reg = PHY_REG_W'($random(seed));
      e.info.fault_vaddr = e.pc;
      if (r.dexc) begin
        e.excp_valid = 1'b1;
        e.excp_code  = 6'h0c;
      end else if (r.kind == kind_mem) begin
        e.info.fault_vaddr = $random(seed);
        if (r.mexc) begin
          e.excp_valid = 1'b1;
          e.excp_code  = 6'h0d;
        end
      end else if (r.redirect) begin
        e.br_redirect    = 1'b1;
        e.info.br_target = $random(seed);
      end
      exp_e.push_back(e);
    end

    // dispatch in pairs, held until accepted
    for (int n = 0; n < num; n += 2) begin
      pair = '0;
      for (int l = 0; l < 2; l++) begin
        if (n + l < num) pair[l] = to_dispatch(exp_e[n+l], stim[first+n+l].dexc);
      end
      @(posedge clk);
      #1;
      dispatch = pair;
      #1;
      waited = 0;
      while (!alloc_ready) begin
        waited++;
        if (waited > TIMEOUT) fail_run("dispatch was never accepted");
        @(posedge clk);
        #2;
      end
      for (int l = 0; l < 2; l++) begin
        if (pair[l].valid) begin
          check_idx($sformatf("alloc_idx[%0d]", l), alloc_idx[l],
                    IDX_W'(tail_model % ROB_DEPTH));
          check_pos($sformatf("alloc_pos[%0d]", l), alloc_pos[l],
                    tail_model >= ROB_DEPTH);
          slot.push_back(tail_model % ROB_DEPTH);
          tail_model = (tail_model + 1) % (2 * ROB_DEPTH);
        end
      end
    end
    @(posedge clk);
    #1;
    dispatch = '0;
    #0.5;

    // nothing has retired yet, the whole batch is occupied
    check_ready("alloc_ready", alloc_ready, num <= ROB_DEPTH - 2);

    // full buffer, offered lanes must not be taken
    if (num > ROB_DEPTH - 2) begin
      pair = '0;
      pair[0].valid = 1'b1;
      pair[0].pc    = 32'hdead_0000;
      pair[1].valid = 1'b1;
      pair[1].pc    = 32'hdead_0004;
      repeat (3) begin
        @(posedge clk);
        #1;
        dispatch = pair;
        #0.5;
        check_ready("alloc_ready", alloc_ready, 1'b0);
        check_idx("alloc_idx[0]", alloc_idx[0], IDX_W'(tail_model % ROB_DEPTH));
        check_pos("alloc_pos[0]", alloc_pos[0], tail_model >= ROB_DEPTH);
      end
      @(posedge clk);
      #1;
      dispatch = '0;
      #0.5;
    end

    // store waits for the head, load goes at once
    if (num >= 2) begin
      mem_wb         = '0;
      mem_wb.rob_idx = ROB_MAX_IDX_W'(slot[1]);
      mem_wb.mem_op  = mem_store;
      #0.5;
      check_ready("mem_wb_ready", mem_wb_ready, 1'b0);
      mem_wb.mem_op  = mem_load;
      #0.5;
      check_ready("mem_wb_ready", mem_wb_ready, 1'b1);
      mem_wb         = '0;
    end

    // younger entries in shuffled order, the oldest last
    for (int n = 1; n < num; n++) begin
      if (!stim[first+n].dexc) order.push_back(n);
    end
    for (int n = order.size() - 1; n > 0; n--) begin
      j        = $unsigned($random(seed)) % (n + 1);
      tmp      = order[n];
      order[n] = order[j];
      order[j] = tmp;
    end
    if (!stim[first].dexc) order.push_back(0);

    port = 0;
    foreach (order[n]) begin
      k = order[n];
      @(posedge clk);
      #1;
      alu_wb = '0;
      mem_wb = '0;
      if (stim[first+k].kind == kind_mem) begin
        mem_wb.valid      = 1'b1;
        mem_wb.rob_idx    = ROB_MAX_IDX_W'(slot[k]);
        mem_wb.mem_op     = stim[first+k].mem_op;
        mem_wb.excp_valid = exp_e[k].excp_valid;
        mem_wb.excp_code  = exp_e[k].excp_code;
        mem_wb.vaddr      = exp_e[k].info.fault_vaddr;
        #1;
        check_ready("mem_wb_ready", mem_wb_ready, 1'b1);
      end else begin
        alu_wb[port].valid       = 1'b1;
        alu_wb[port].rob_idx     = ROB_MAX_IDX_W'(slot[k]);
        alu_wb[port].br_redirect = exp_e[k].br_redirect;
        alu_wb[port].br_target   = exp_e[k].info.br_target;
        port = 1 - port;
      end
    end
    @(posedge clk);
    #1;
    alu_wb = '0;
    mem_wb = '0;

    // drain and compare against the model
    foreach (exp_e[n]) model_q.push_back(exp_e[n]);
    waited = 0;
    while (model_q.size() > 0) begin
      @(posedge clk);
      #1;
      if (commit.valid != 2'b00) begin
        exp_vld = expected_group();
        check_commit_valid(commit.valid, exp_vld);
        check_entry("commit.entry[0]", commit.entry[0], model_q.pop_front());
        if (exp_vld[1]) check_entry("commit.entry[1]", commit.entry[1], model_q.pop_front());
        waited = 0;
      end else begin
        waited++;
        if (waited > TIMEOUT) fail_run("commit stalled with entries outstanding");
      end
    end
    repeat (3) begin
      @(posedge clk);
      #1;
      check_commit_valid(commit.valid, 2'b00);
    end
    check_ready("alloc_ready", alloc_ready, 1'b1);
  endtask

  // two entries in flight, then flush
  task automatic flush_test();
    dispatch_t [DISPATCH_WIDTH-1:0] pair;
    pair = '0;
    // complete on arrival, only the flush keeps them from retiring
    for (int l = 0; l < 2; l++) begin
      pair[l].valid      = 1'b1;
      pair[l].pc         = 32'h0000_2000 + 32'(l * 4);
      pair[l].kind       = kind_alu;
      pair[l].excp_valid = 1'b1;
      pair[l].excp_code  = 6'h0c;
    end
    @(posedge clk);
    #1;
    dispatch = pair;
    #1;
    check_ready("alloc_ready", alloc_ready, 1'b1);
    @(posedge clk);
    #1;
    dispatch = '0;
    flush    = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    #1;
    check_ready("alloc_ready", alloc_ready, 1'b1);
    repeat (4) begin
      @(posedge clk);
      #1;
      check_commit_valid(commit.valid, 2'b00);
    end
    tail_model = 0;
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    int first;
    int num;
    int batch_no;
    seed       = 32'hcaf0425a;
    clk        = 1'b0;
    rst_n      = 1'b0;
    flush      = 1'b0;
    dispatch   = '0;
    alu_wb     = '0;
    mem_wb     = '0;
    tail_model = 0;

    // out of order alu completion
    add_row(kind_alu, 0, 0, mem_load, 0, 0);
    add_row(kind_alu, 0, 0, mem_load, 0, 0);
    add_row(kind_alu, 0, 0, mem_load, 0, 0);
    add_row(kind_alu, 0, 0, mem_load, 0, 1);
    // adjacent branches
    add_row(kind_branch, 0, 0, mem_load, 0, 0);
    add_row(kind_branch, 0, 0, mem_load, 0, 0);
    add_row(kind_alu, 0, 0, mem_load, 0, 0);
    add_row(kind_alu, 0, 0, mem_load, 0, 1);
    // redirect and dispatch exception
    add_row(kind_alu, 0, 0, mem_load, 0, 0);
    add_row(kind_branch, 1, 0, mem_load, 0, 0);
    add_row(kind_alu, 0, 0, mem_load, 0, 0);
    add_row(kind_other, 0, 1, mem_load, 0, 0);
    add_row(kind_alu, 0, 0, mem_load, 0, 1);
    // store at the head, loads behind it
    add_row(kind_mem, 0, 0, mem_store, 0, 0);
    add_row(kind_mem, 0, 0, mem_load, 0, 0);
    add_row(kind_mem, 0, 0, mem_load, 1, 0);
    add_row(kind_alu, 0, 0, mem_load, 0, 1);
    // fill the buffer
    for (int n = 0; n < ROB_DEPTH; n++) begin
      add_row(kind_alu, 0, 0, mem_load, 0, n == ROB_DEPTH - 1);
    end
    // after flush
    add_row(kind_alu, 0, 0, mem_load, 0, 0);
    add_row(kind_alu, 0, 0, mem_load, 0, 1);

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    #1;
    check_ready("alloc_ready", alloc_ready, 1'b1);
    check_commit_valid(commit.valid, 2'b00);

    first    = 0;
    batch_no = 0;
    while (first < stim.size()) begin
      num = 1;
      while (!stim[first+num-1].last) num++;
      run_batch(first, num);
      if (batch_no == 4) flush_test();
      first += num;
      batch_no++;
    end

    $display("Everything OK");
    $finish;
  end

endmodule

// File: vlog.f
design/rob_pkg.sv
design/rob_alloc.sv
design/rob_table.sv
design/rob_commit.sv
design/rob_top.sv
tests/rob_properties.sv
tests/tb_rob.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the reorder buffer simulation with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_rob -o tb_rob
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rob > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
